/* Makefile */
# Verilator build and run for the frame DRAM bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_frame_dram_bridge
FLIST     ?= frame_dram_bridge.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* design/bridge_config_regs.sv */
// Host register block: enable, read mode and buffer limit,
// plus the dropped-frame count and queue occupancy for status.
`timescale 1ns/10ps
`default_nettype none

module bridge_config_regs (
   input  wire                            clki,
   input  wire                            rresetb,
   input  wire                            cfg_we,
   input  wire frame_dram_pkg::cfg_addr_t cfg_addr,
   input  wire frame_dram_pkg::cfg_data_t cfg_wdata,
   input  wire                            drop,
   input  wire frame_dram_pkg::qcount_t   occupancy,
   output frame_dram_pkg::cfg_data_t      cfg_rdata,
   output logic                           enable,
   output logic                           read_mode,
   output frame_dram_pkg::cfg_data_t      num_buffers
);
   frame_dram_pkg::cfg_data_t dropped;

   always_ff @(posedge clki or negedge rresetb) begin
      if (!rresetb) begin
         enable      <= 1'b0;
         read_mode   <= 1'b0;
         num_buffers <= frame_dram_pkg::NUM_BUFFERS_RESET;
         dropped     <= '0;
      end else begin
         if (cfg_we && cfg_addr == frame_dram_pkg::CFG_CTRL) begin
            enable    <= cfg_wdata[0];
            read_mode <= cfg_wdata[1];
         end
         if (cfg_we && cfg_addr == frame_dram_pkg::CFG_NUM_BUFFERS) begin
            num_buffers <= cfg_wdata;
         end
         if (drop && dropped != 8'hff) begin // saturate
            dropped <= dropped + 8'd1;
         end
      end
   end

   always_comb begin
      case (cfg_addr)
         frame_dram_pkg::CFG_CTRL:        cfg_rdata = {6'b0, read_mode, enable};
         frame_dram_pkg::CFG_NUM_BUFFERS: cfg_rdata = num_buffers;
         frame_dram_pkg::CFG_DROPPED:     cfg_rdata = dropped;
         default:                         cfg_rdata = {4'b0, occupancy};
      endcase
   end

endmodule

`default_nettype wire

/* design/dram_read_unpacker.sv */
// Read side of the bridge. Pops a frame, requests it in 16-word bursts
// with a bounded number of words in flight, and hands each DRAM word
// to the device as two half-words, low half first.
`timescale 1ns/10ps
`default_nettype none

module dram_read_unpacker (
   input  wire                        clki,
   input  wire                        rresetb,
   input  wire                        enable,
   input  wire                        read_mode,
   input  wire                        busy_wr,
   input  wire frame_dram_pkg::desc_t head,
   input  wire                        empty,
   input  wire                        cmd_full,
   input  wire frame_dram_pkg::word_t rd_data,
   input  wire                        rd_empty,
   input  wire                        di_read,
   output logic                       pop,
   output logic                       rd_cmd_en,
   output frame_dram_pkg::addr_t      rd_cmd_addr,
   output logic                       rd_en,
   output logic                       di_read_rdy,
   output frame_dram_pkg::pix_t       di_data
);
   typedef enum logic {IDLE, READ_FRAME} state_t;

   state_t                state;
   frame_dram_pkg::addr_t req_left;    // bytes not yet requested
   frame_dram_pkg::addr_t half_left;   // half-words not yet delivered
   logic [5:0]            outstanding; // requested words not yet taken
   logic                  cmd_prev;
   logic                  have_hi;
   logic                  take;
   logic                  rd_pend;
   frame_dram_pkg::pix_t  hi_half;

   assign pop     = enable && read_mode && state == IDLE && !empty;
   assign take    = di_read && di_read_rdy;
   assign rd_en   = state == READ_FRAME && !rd_empty && (!di_read_rdy || (take && !have_hi));
   assign rd_pend = state == READ_FRAME && req_left != '0 &&
                    outstanding <= 6'(frame_dram_pkg::MAX_OUTSTANDING - frame_dram_pkg::BURST_WORDS);
   assign rd_cmd_en = rd_pend && !busy_wr && !cmd_full && !cmd_prev;

   always_ff @(posedge clki or negedge rresetb) begin
      if (!rresetb) begin
         state       <= IDLE;
         req_left    <= '0;
         half_left   <= '0;
         outstanding <= '0;
         cmd_prev    <= 1'b0;
         have_hi     <= 1'b0;
         di_read_rdy <= 1'b0;
      end else if (!enable) begin
         state       <= IDLE;
         req_left    <= '0;
         half_left   <= '0;
         outstanding <= '0;
         cmd_prev    <= 1'b0;
         have_hi     <= 1'b0;
         di_read_rdy <= 1'b0;
      end else begin
         cmd_prev    <= rd_cmd_en;
         outstanding <= outstanding + (rd_cmd_en ? 6'(frame_dram_pkg::BURST_WORDS) : 6'd0)
                        - (rd_en ? 6'd1 : 6'd0);
         if (rd_cmd_en) req_left <= req_left - frame_dram_pkg::addr_t'(frame_dram_pkg::BURST_BYTES);
         if (take) half_left <= half_left - 30'd1;

         if (rd_en) begin
            have_hi     <= 1'b1;
            di_read_rdy <= 1'b1;
         end else if (take) begin
            if (have_hi) have_hi <= 1'b0;
            else di_read_rdy <= 1'b0; // nothing left to show
         end

         case (state)
            IDLE: begin
               if (pop) begin
                  req_left  <= head.len;
                  half_left <= head.len >> 1;
                  state     <= READ_FRAME;
               end
            end
            default: if (half_left == '0) state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clki) begin
      if (pop) rd_cmd_addr <= head.base;
      else if (rd_cmd_en) begin
         rd_cmd_addr <= rd_cmd_addr + frame_dram_pkg::addr_t'(frame_dram_pkg::BURST_BYTES);
      end
      if (rd_en) begin
         di_data <= rd_data[15:0];
         hi_half <= rd_data[31:16];
      end else if (take && have_hi) begin
         di_data <= hi_half;
      end
   end

endmodule

`default_nettype wire

/* design/frame_dram_bridge.sv */
// Top of the pixel stream to DRAM bridge.
// Packs a 16-bit stream into DRAM bursts, queues whole frames and
// plays them back on the device side through one shared MIG port.
`timescale 1ns/10ps
`default_nettype none

module frame_dram_bridge (
   input  wire                            clki,
   input  wire                            rresetb,
   input  wire                            dvi,
   input  wire frame_dram_pkg::dtype_t    dtypei,
   input  wire frame_dram_pkg::pix_t      datai,
   input  wire                            cfg_we,
   input  wire frame_dram_pkg::cfg_addr_t cfg_addr,
   input  wire frame_dram_pkg::cfg_data_t cfg_wdata,
   output wire frame_dram_pkg::cfg_data_t cfg_rdata,
   output wire                            wr_en,
   output wire frame_dram_pkg::word_t     wr_data,
   output wire                            cmd_en,
   output wire frame_dram_pkg::cmd_t      cmd_instr,
   output wire frame_dram_pkg::bl_t       cmd_bl,
   output wire frame_dram_pkg::addr_t     cmd_byte_addr,
   input  wire                            cmd_full,
   output wire                            rd_en,
   input  wire frame_dram_pkg::word_t     rd_data,
   input  wire                            rd_empty,
   input  wire                            di_read,
   output wire                            di_read_rdy,
   output wire frame_dram_pkg::pix_t      di_data
);
   wire                            enable;
   wire                            read_mode;
   wire frame_dram_pkg::cfg_data_t num_buffers;
   wire                            drop;
   wire frame_dram_pkg::qcount_t   occupancy;
   wire                            wr_cmd_en;
   wire frame_dram_pkg::bl_t       wr_cmd_bl;
   wire frame_dram_pkg::addr_t     wr_cmd_addr;
   wire                            busy_wr;
   wire                            commit;
   wire frame_dram_pkg::desc_t     commit_desc;
   wire                            committed;
   wire                            pop;
   wire frame_dram_pkg::desc_t     head;
   wire                            empty;
   wire                            rd_cmd_en;
   wire frame_dram_pkg::addr_t     rd_cmd_addr;

   // packer owns the command port for as long as busy_wr is high
   assign cmd_en        = (busy_wr && wr_cmd_en) || (!busy_wr && rd_cmd_en);
   assign cmd_instr     = !cmd_en ? frame_dram_pkg::CMD_IDLE :
                          busy_wr ? frame_dram_pkg::CMD_WRITE : frame_dram_pkg::CMD_READ;
   assign cmd_bl        = busy_wr ? wr_cmd_bl :
                          frame_dram_pkg::bl_t'(frame_dram_pkg::BURST_WORDS - 1);
   assign cmd_byte_addr = busy_wr ? wr_cmd_addr : rd_cmd_addr;

   bridge_config_regs u_cfg (
      .clki, .rresetb, .cfg_we, .cfg_addr, .cfg_wdata, .drop, .occupancy,
      .cfg_rdata, .enable, .read_mode, .num_buffers
   );

   stream_write_packer u_packer (
      .clki, .rresetb, .enable, .dvi, .dtypei, .datai, .cmd_full, .committed,
      .wr_en, .wr_data, .wr_cmd_en, .wr_cmd_bl, .wr_cmd_addr, .busy_wr,
      .commit, .commit_desc
   );

   frame_queue u_queue (
      .clki, .rresetb, .enable, .num_buffers, .commit, .commit_desc, .pop,
      .committed, .drop, .head, .empty, .occupancy
   );

   dram_read_unpacker u_unpacker (
      .clki, .rresetb, .enable, .read_mode, .busy_wr, .head, .empty, .cmd_full,
      .rd_data, .rd_empty, .di_read, .pop, .rd_cmd_en, .rd_cmd_addr, .rd_en,
      .di_read_rdy, .di_data
   );

endmodule

`default_nettype wire

/* design/frame_dram_pkg.sv */
// Shared widths, types and codes for the pixel stream to DRAM bridge.
// Every design file refers to these by frame_dram_pkg::name.
`default_nettype none

package frame_dram_pkg;

   localparam int ADDR_W  = 30;
   localparam int DTYPE_W = 3;

   typedef logic [ADDR_W-1:0]  addr_t;   // DRAM byte address
   typedef logic [31:0]        word_t;
   typedef logic [15:0]        pix_t;
   typedef logic [DTYPE_W-1:0] dtype_t;
   typedef logic [2:0]         cmd_t;
   typedef logic [5:0]         bl_t;     // burst length minus one
   typedef logic [3:0]         qcount_t;
   typedef logic [1:0]         cfg_addr_t;
   typedef logic [7:0]         cfg_data_t;

   localparam dtype_t DTYPE_FRAME_START = 3'd1;
   localparam dtype_t DTYPE_PIXEL       = 3'd2;
   localparam dtype_t DTYPE_FRAME_END   = 3'd3;

   localparam cmd_t CMD_WRITE = 3'd0;
   localparam cmd_t CMD_READ  = 3'd1;
   localparam cmd_t CMD_IDLE  = 3'd5;

   localparam int BURST_WORDS     = 16;
   localparam int BURST_BYTES     = 64;
   localparam int MAX_OUTSTANDING = 32; // read words in flight
   localparam int QUEUE_DEPTH     = 8;

   localparam cfg_addr_t CFG_CTRL        = 2'd0; // bit0 enable, bit1 read mode
   localparam cfg_addr_t CFG_NUM_BUFFERS = 2'd1;
   localparam cfg_addr_t CFG_DROPPED     = 2'd2;
   localparam cfg_addr_t CFG_OCCUPANCY   = 2'd3;
   localparam cfg_data_t NUM_BUFFERS_RESET = 8'd2;

   typedef struct packed {
      addr_t base;
      addr_t len;  // byte length, multiple of 64
   } desc_t;

endpackage

`default_nettype wire

/* design/frame_queue.sv */
// Ring of committed frame descriptors between the write and read sides.
// A commit is stored only while occupancy is below the buffer limit.
`timescale 1ns/10ps
`default_nettype none

module frame_queue (
   input  wire                            clki,
   input  wire                            rresetb,
   input  wire                            enable,
   input  wire frame_dram_pkg::cfg_data_t num_buffers,
   input  wire                            commit,
   input  wire frame_dram_pkg::desc_t     commit_desc,
   input  wire                            pop,
   output logic                           committed,
   output logic                           drop,
   output frame_dram_pkg::desc_t          head,
   output logic                           empty,
   output frame_dram_pkg::qcount_t        occupancy
);
   frame_dram_pkg::desc_t ring [frame_dram_pkg::QUEUE_DEPTH];

   logic [$clog2(frame_dram_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
   logic [$clog2(frame_dram_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
   logic                                           do_pop;

   assign committed = commit && frame_dram_pkg::cfg_data_t'(occupancy) < num_buffers &&
                      occupancy < frame_dram_pkg::qcount_t'(frame_dram_pkg::QUEUE_DEPTH);
   assign drop      = commit && !committed;
   assign do_pop    = pop && !empty;
   assign empty     = occupancy == '0;
   assign head      = ring[rd_ptr];

   always_ff @(posedge clki or negedge rresetb) begin
      if (!rresetb) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         occupancy <= '0;
      end else if (!enable) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         occupancy <= '0;
      end else begin
         if (committed) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         occupancy <= occupancy + (committed ? 4'd1 : 4'd0) - (do_pop ? 4'd1 : 4'd0);
      end
   end

   always_ff @(posedge clki) begin
      if (committed) ring[wr_ptr] <= commit_desc;
   end

endmodule

`default_nettype wire

/* design/stream_write_packer.sv */
// Write side of the bridge. Packs pixel half-words into 32-bit words,
// issues 16-word write bursts, drains the tail at frame end and then
// offers a descriptor to the frame queue.
`timescale 1ns/10ps
`default_nettype none

module stream_write_packer (
   input  wire                         clki,
   input  wire                         rresetb,
   input  wire                         enable,
   input  wire                         dvi,
   input  wire frame_dram_pkg::dtype_t dtypei,
   input  wire frame_dram_pkg::pix_t   datai,
   input  wire                         cmd_full,
   input  wire                         committed,
   output logic                        wr_en,
   output frame_dram_pkg::word_t       wr_data,
   output logic                        wr_cmd_en,
   output frame_dram_pkg::bl_t         wr_cmd_bl,
   output frame_dram_pkg::addr_t       wr_cmd_addr,
   output logic                        busy_wr,
   output logic                        commit,
   output frame_dram_pkg::desc_t       commit_desc
);
   typedef enum logic [1:0] {WAIT_FRAME, WRITE_FRAME, DRAIN} state_t;

   state_t                state;
   logic                  wsel;      // high half of the word is next
   logic                  cmd_prev;
   logic                  want_cmd;
   logic                  pix_in;
   logic                  end_in;
   logic                  start_in;
   logic [5:0]            wcount;    // words sitting in the controller write fifo
   frame_dram_pkg::addr_t base;
   frame_dram_pkg::addr_t frame_len;

   assign start_in = dvi && dtypei == frame_dram_pkg::DTYPE_FRAME_START && state == WAIT_FRAME;
   assign pix_in   = dvi && dtypei == frame_dram_pkg::DTYPE_PIXEL && state == WRITE_FRAME;
   assign end_in   = dvi && dtypei == frame_dram_pkg::DTYPE_FRAME_END && state == WRITE_FRAME;
   assign busy_wr  = state != WAIT_FRAME;

   // tail bursts wait until the odd-half flush word has landed
   assign want_cmd = (state == WRITE_FRAME && wcount >= 6'(frame_dram_pkg::BURST_WORDS)) ||
                     (state == DRAIN && wcount != '0 && !wr_en);
   assign wr_cmd_en = want_cmd && !cmd_full && !cmd_prev;
   assign wr_cmd_bl = (wcount >= 6'(frame_dram_pkg::BURST_WORDS)) ?
                      frame_dram_pkg::bl_t'(frame_dram_pkg::BURST_WORDS - 1) : wcount - 6'd1;

   assign commit_desc.base = base;
   assign commit_desc.len  = (frame_len + frame_dram_pkg::addr_t'(frame_dram_pkg::BURST_BYTES - 1))
                             & ~frame_dram_pkg::addr_t'(frame_dram_pkg::BURST_BYTES - 1);

   always_ff @(posedge clki or negedge rresetb) begin
      if (!rresetb) begin
         state    <= WAIT_FRAME;
         wsel     <= 1'b0;
         wr_en    <= 1'b0;
         wcount   <= '0;
         commit   <= 1'b0;
         cmd_prev <= 1'b0;
         base     <= '0;
      end else if (!enable) begin
         state    <= WAIT_FRAME;
         wsel     <= 1'b0;
         wr_en    <= 1'b0;
         wcount   <= '0;
         commit   <= 1'b0;
         cmd_prev <= 1'b0;
         base     <= '0;
      end else begin
         cmd_prev <= wr_cmd_en;
         wr_en    <= wsel && (pix_in || end_in);
         wcount   <= wcount + (wr_en ? 6'd1 : 6'd0) - (wr_cmd_en ? wr_cmd_bl + 6'd1 : 6'd0);
         if (pix_in) wsel <= !wsel;
         else if (end_in) wsel <= 1'b0;

         case (state)
            WAIT_FRAME:  if (start_in) state <= WRITE_FRAME;
            WRITE_FRAME: if (end_in) state <= DRAIN;
            default: begin
               if (commit) begin
                  commit <= 1'b0;
                  state  <= WAIT_FRAME;
                  if (committed) base <= base + commit_desc.len; // dropped frames reuse it
               end else if (wcount == '0 && !wr_en) begin
                  commit <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clki) begin
      if (start_in) begin
         wr_cmd_addr <= base;
         frame_len   <= '0;
      end else if (wr_cmd_en) begin
         wr_cmd_addr <= wr_cmd_addr + frame_dram_pkg::addr_t'(frame_dram_pkg::BURST_BYTES);
      end
      if (pix_in) begin
         frame_len <= frame_len + 30'd2;
         if (wsel) wr_data[31:16] <= datai;
         else wr_data[15:0] <= datai;
      end else if (end_in && wsel) begin
         wr_data[31:16] <= '0; // odd frame, pad the upper half
      end
   end

endmodule

`default_nettype wire

/* frame_dram_bridge.f */
design/frame_dram_pkg.sv
design/bridge_config_regs.sv
design/stream_write_packer.sv
design/frame_queue.sv
design/dram_read_unpacker.sv
design/frame_dram_bridge.sv
verif/tb_clock_gen.sv
verif/mig_port_model.sv
verif/frame_dram_checker.sv
verif/tb_frame_dram_bridge.sv

/* verif/frame_dram_checker.sv */
// Port protocol assertions, bound onto the bridge top level.
`timescale 1ns/10ps
`default_nettype none

module frame_dram_checker (
   input wire clki,
   input wire rresetb,
   input wire wr_en,
   input wire cmd_en,
   input wire cmd_full,
   input wire rd_en,
   input wire rd_empty,
   input wire di_read_rdy
);
   int fails = 0; // read by the testbench at the end

   cmd_single: assert property (@(posedge clki) disable iff (!rresetb) cmd_en |=> !cmd_en)
      else begin $error("cmd_en high two cycles in a row"); fails++; end

   cmd_not_full: assert property (@(posedge clki) disable iff (!rresetb) cmd_en |-> !cmd_full)
      else begin $error("cmd_en while cmd_full"); fails++; end

   rd_not_empty: assert property (@(posedge clki) disable iff (!rresetb) rd_en |-> !rd_empty)
      else begin $error("rd_en while rd_empty"); fails++; end

   // outputs quiet while in reset
   reset_quiet: assert property (@(posedge clki) !rresetb |-> !wr_en && !cmd_en && !di_read_rdy)
      else begin $error("output active during reset"); fails++; end

endmodule

bind frame_dram_bridge frame_dram_checker chk (.*);

`default_nettype wire

/* verif/mig_port_model.sv */
// Behavioral MIG-style port: write fifo, sparse word memory, read return fifo.
// Returns one read word per cycle in order, cmd_full optionally random.
`timescale 1ns/10ps
`default_nettype none

module mig_port_model (
   input  wire                        clki,
   input  wire                        rresetb,
   input  wire                        flush,      // drops all queued words
   input  wire                        rand_full,
   input  wire                        wr_en,
   input  wire frame_dram_pkg::word_t wr_data,
   input  wire                        cmd_en,
   input  wire frame_dram_pkg::cmd_t  cmd_instr,
   input  wire frame_dram_pkg::bl_t   cmd_bl,
   input  wire frame_dram_pkg::addr_t cmd_byte_addr,
   input  wire                        rd_en,
   output logic                       cmd_full,
   output frame_dram_pkg::word_t      rd_data,
   output logic                       rd_empty
);
   frame_dram_pkg::word_t mem [int];
   frame_dram_pkg::word_t wfifo [$];
   frame_dram_pkg::word_t rfifo [$];
   int                    pend [$];   // word addresses still to return
   int                    errors = 0;
   int                    seed = 91788;

   initial begin
      cmd_full = 1'b0;
      rd_data  = '0;
      rd_empty = 1'b1;
   end

   always @(posedge clki) begin
      int waddr;
      if (!rresetb || flush) begin
         wfifo.delete();
         rfifo.delete();
         pend.delete();
      end else begin
         if (wr_en) wfifo.push_back(wr_data);
         if (rd_en) begin
            if (rfifo.size() == 0) errors++;
            else void'(rfifo.pop_front());
         end
         if (pend.size() > 0) begin
            waddr = pend.pop_front();
            rfifo.push_back(mem.exists(waddr) ? mem[waddr] : '0); // unwritten reads zero
         end
         if (cmd_en) begin
            if (cmd_full) errors++;
            waddr = int'(cmd_byte_addr >> 2);
            for (int i = 0; i <= int'(cmd_bl); i++) begin
               if (cmd_instr == frame_dram_pkg::CMD_WRITE) begin
                  if (wfifo.size() == 0) errors++;
                  else mem[waddr + i] = wfifo.pop_front();
               end else if (cmd_instr == frame_dram_pkg::CMD_READ) begin
                  pend.push_back(waddr + i);
               end
            end
         end
      end
      #1;
      cmd_full = rand_full && (($random(seed) & 3) == 0);
      rd_empty = rfifo.size() == 0;
      rd_data  = (rfifo.size() > 0) ? rfifo[0] : '0;
   end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset: 100 ns clock, reset held low for 4 cycles.
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic clki,
   output logic rresetb
);
   initial begin
      clki = 1'b0;
      forever #50 clki = !clki;
   end

   initial begin
      rresetb = 1'b1;
      #5 rresetb = 1'b0; // real falling edge for the async reset
      repeat (4) @(posedge clki);
      #1 rresetb = 1'b1;
   end

endmodule

`default_nettype wire

/* verif/tb_frame_dram_bridge.sv */
// Testbench for the frame DRAM bridge. Applies a table of frame tests,
// checks write commands, stored words, status registers and read-back.
`timescale 1ns/10ps
`default_nettype none

module tb_frame_dram_bridge;
   localparam int NROWS    = 5;
   localparam int MAX_WAIT = 2000;

   // frame length in half-words, buffer limit, frames, random cmd_full/di_read, disable
   int tbl_len    [NROWS] = '{64, 37, 32, 100, 64};
   int tbl_nbuf   [NROWS] = '{2, 2, 2, 4, 2};
   int tbl_frames [NROWS] = '{1, 2, 3, 3, 1};
   bit tbl_rand   [NROWS] = '{0, 0, 0, 1, 0};
   bit tbl_dis    [NROWS] = '{0, 0, 0, 0, 1};

   logic clki, rresetb, dvi, cfg_we, wr_en, cmd_en, cmd_full, rd_en, rd_empty;
   logic di_read, di_read_rdy, flush, rand_full;
   frame_dram_pkg::dtype_t    dtypei;
   frame_dram_pkg::pix_t      datai, di_data;
   frame_dram_pkg::cfg_addr_t cfg_addr;
   frame_dram_pkg::cfg_data_t cfg_wdata, cfg_rdata;
   frame_dram_pkg::word_t     wr_data, rd_data;
   frame_dram_pkg::cmd_t      cmd_instr;
   frame_dram_pkg::bl_t       cmd_bl;
   frame_dram_pkg::addr_t     cmd_byte_addr;

   int seed = 91788;
   frame_dram_pkg::word_t ref_mem [int]; // expected DRAM contents by word address
   frame_dram_pkg::addr_t exp_base;
   frame_dram_pkg::addr_t q_base [$];
   frame_dram_pkg::addr_t q_len [$];
   frame_dram_pkg::addr_t wcmd_addr [$];
   frame_dram_pkg::bl_t   wcmd_bl [$];
   int tb_occ, tb_drops, errors, checks, tests_failed;
   bit test_fail;

   tb_clock_gen u_clk (.clki, .rresetb);
   frame_dram_bridge dut (.*);
   mig_port_model u_mig (.*);

   always @(posedge clki) begin
      if (cmd_en && cmd_instr == frame_dram_pkg::CMD_WRITE) begin
         wcmd_addr.push_back(cmd_byte_addr);
         wcmd_bl.push_back(cmd_bl);
      end
   end

   task automatic check(string name, logic [63:0] got, logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
         test_fail = 1'b1;
      end
   endtask

   function automatic frame_dram_pkg::word_t ref_word(int a);
      return ref_mem.exists(a) ? ref_mem[a] : '0;
   endfunction

   task automatic next_cycle();
      @(posedge clki);
      #1;
   endtask

   task automatic cfg_write(frame_dram_pkg::cfg_addr_t a, frame_dram_pkg::cfg_data_t d);
      cfg_we    = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
      next_cycle();
      cfg_we = 1'b0;
   endtask

   task automatic cfg_read(frame_dram_pkg::cfg_addr_t a, output frame_dram_pkg::cfg_data_t v);
      cfg_addr = a;
      #10 v = cfg_rdata;
      next_cycle();
   endtask

   task automatic stream_word(frame_dram_pkg::dtype_t t, frame_dram_pkg::pix_t d);
      dvi    = 1'b1;
      dtypei = t;
      datai  = d;
      next_cycle();
      dvi = 1'b0;
   endtask

   task automatic write_frame(int len, int nbuf);
      int words, nb, w0, n;
      bit done;
      frame_dram_pkg::pix_t  p;
      frame_dram_pkg::addr_t base, rounded;
      words   = (len + 1) / 2;
      nb      = (words + 15) / 16;
      base    = exp_base;
      w0      = int'(base >> 2);
      rounded = frame_dram_pkg::addr_t'(((len * 2 + 63) / 64) * 64);
      wcmd_addr.delete();
      wcmd_bl.delete();
      stream_word(frame_dram_pkg::DTYPE_FRAME_START, '0);
      for (int i = 0; i < len; i++) begin
         p = 16'($random(seed));
         if (i % 2 == 0) ref_mem[w0 + i / 2] = {16'h0, p}; // low half first
         else ref_mem[w0 + i / 2][31:16] = p;
         stream_word(frame_dram_pkg::DTYPE_PIXEL, p);
      end
      stream_word(frame_dram_pkg::DTYPE_FRAME_END, '0);
      n    = 0;
      done = 1'b0;
      while (!done && n < MAX_WAIT) begin
         if (dut.commit) done = 1'b1;
         else begin
            next_cycle();
            n++;
         end
      end
      if (!done) begin
         $display("frame at base 0x%0h was never committed", base);
         errors++;
         test_fail = 1'b1;
         return;
      end
      next_cycle(); // packer back in its wait state
      if (tb_occ < nbuf) begin
         q_base.push_back(base);
         q_len.push_back(rounded);
         tb_occ++;
         exp_base = base + rounded;
      end else tb_drops++;
      check("write_cmds", wcmd_addr.size(), nb);
      for (int k = 0; k < wcmd_addr.size() && k < nb; k++) begin
         check("cmd_byte_addr", wcmd_addr[k], base + 64 * k);
         check("cmd_bl", wcmd_bl[k], (k == nb - 1) ? (words - 1) % 16 : 15);
      end
      for (int i = 0; i < words; i++) check("mem_word", u_mig.mem[w0 + i], ref_word(w0 + i));
   endtask

   task automatic read_back(bit rnd);
      frame_dram_pkg::addr_t b, l;
      frame_dram_pkg::word_t w;
      frame_dram_pkg::pix_t  e;
      int  n;
      bit  got;
      cfg_write(frame_dram_pkg::CFG_CTRL, 8'h03);
      while (q_len.size() > 0) begin
         b = q_base.pop_front();
         l = q_len.pop_front();
         for (int h = 0; h < int'(l / 2); h++) begin
            w   = ref_word(int'(b >> 2) + h / 2);
            e   = h[0] ? w[31:16] : w[15:0];
            got = 1'b0;
            n   = 0;
            while (!got && n < MAX_WAIT) begin
               if (di_read_rdy && (!rnd || ($random(seed) & 1))) begin
                  check("di_data", di_data, e);
                  di_read = 1'b1;
                  next_cycle();
                  di_read = 1'b0;
                  got     = 1'b1;
               end else begin
                  next_cycle();
                  n++;
               end
            end
            if (!got) begin
               $display("di_read_rdy never rose for half-word %0d of frame at 0x%0h", h, b);
               errors++;
               test_fail = 1'b1;
               return;
            end
         end
      end
      tb_occ = 0;
      cfg_write(frame_dram_pkg::CFG_CTRL, 8'h01);
   endtask

   task automatic run_row(int r);
      frame_dram_pkg::cfg_data_t v;
      test_fail = 1'b0;
      rand_full = tbl_rand[r];
      cfg_write(frame_dram_pkg::CFG_NUM_BUFFERS, 8'(tbl_nbuf[r]));
      if (tbl_dis[r]) begin
         write_frame(tbl_len[r], tbl_nbuf[r]);
         stream_word(frame_dram_pkg::DTYPE_FRAME_START, '0);
         repeat (tbl_len[r] / 2) stream_word(frame_dram_pkg::DTYPE_PIXEL, 16'($random(seed)));
         flush = 1'b1; // abandon words left in the model fifo
         cfg_write(frame_dram_pkg::CFG_CTRL, 8'h00);
         next_cycle();
         next_cycle();
         flush = 1'b0;
         cfg_read(frame_dram_pkg::CFG_OCCUPANCY, v);
         check("occupancy", v, 0);
         q_base.delete();
         q_len.delete();
         tb_occ   = 0;
         exp_base = '0;
         cfg_write(frame_dram_pkg::CFG_CTRL, 8'h01);
         write_frame(tbl_len[r], tbl_nbuf[r]);
      end else begin
         repeat (tbl_frames[r]) write_frame(tbl_len[r], tbl_nbuf[r]);
      end
      cfg_read(frame_dram_pkg::CFG_DROPPED, v);
      check("dropped", v, 8'(tb_drops));
      cfg_read(frame_dram_pkg::CFG_OCCUPANCY, v);
      check("occupancy", v, tb_occ);
      read_back(tbl_rand[r]);
      check("di_read_rdy", di_read_rdy, 0);
      rand_full = 1'b0;
      if (test_fail) tests_failed++;
      $display("test %0d len %0d frames %0d: %s", r + 1, tbl_len[r], tbl_frames[r],
               test_fail ? "failed" : "ok");
   endtask

   initial begin
      frame_dram_pkg::cfg_data_t v;
      dvi = 1'b0;
      dtypei = '0;
      datai = '0;
      cfg_we = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      di_read = 1'b0;
      flush = 1'b0;
      rand_full = 1'b0;
      exp_base = '0;
      {tb_occ, tb_drops, errors, checks, tests_failed} = '0;
      wait (rresetb === 1'b0);
      wait (rresetb === 1'b1);
      next_cycle();
      test_fail = 1'b0;
      check("wr_en", wr_en, 0);
      check("cmd_en", cmd_en, 0);
      check("rd_en", rd_en, 0);
      check("di_read_rdy", di_read_rdy, 0);
      check("cmd_instr", cmd_instr, frame_dram_pkg::CMD_IDLE);
      cfg_read(frame_dram_pkg::CFG_NUM_BUFFERS, v);
      check("num_buffers", v, 2);
      cfg_read(frame_dram_pkg::CFG_DROPPED, v);
      check("dropped", v, 0);
      cfg_read(frame_dram_pkg::CFG_OCCUPANCY, v);
      check("occupancy", v, 0);
      if (test_fail) tests_failed++;
      $display("test 0 reset: %s", test_fail ? "failed" : "ok");
      cfg_write(frame_dram_pkg::CFG_CTRL, 8'h01);
      for (int r = 0; r < NROWS; r++) run_row(r);
      check("model_errors", u_mig.errors, 0);
      errors = errors + dut.chk.fails;
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               NROWS + 1, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // limit is 20 cycles per half-word in the table plus a margin
   initial begin
      int total;
      total = 0;
      for (int r = 0; r < NROWS; r++) total += tbl_len[r] * (tbl_frames[r] + tbl_dis[r]);
      repeat (total * 20 + 5000) @(posedge clki);
      $display("watchdog: run did not finish within %0d cycles", total * 20 + 5000);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
